// ==== source/mask_types_pkg.sv ====
package mask_types_pkg;

  // Width of one Boolean share
  localparam int XLEN = 32;

  // Shift amount field of the second operand
  localparam int SHAMT_W = 5;

  typedef logic [XLEN-1:0] share_t;

  // Share 0 of rs2 is either a data share or carries a shift amount
  typedef union packed {
    share_t data;
    struct packed {
      logic [XLEN-SHAMT_W-1:0] rsvd;    // Ignored by the shifter
      logic [SHAMT_W-1:0]      shamt;
    } shift;
  } operand2_u;

  // LFSR state after reset, any value but all ones
  localparam share_t LFSR_SEED = 32'h6789_abcd;

endpackage

// ==== source/alu_op_pkg.sv ====
package alu_op_pkg;

  // Op codes 11 to 15 are reserved
  typedef enum logic [3:0] {
    OP_NOT    = 4'd0,
    OP_XOR    = 4'd1,
    OP_AND    = 4'd2,
    OP_IOR    = 4'd3,
    OP_ADD    = 4'd4,
    OP_SUB    = 4'd5,
    OP_SRLI   = 4'd6,
    OP_SLLI   = 4'd7,
    OP_RORI   = 4'd8,
    OP_MASK   = 4'd9,
    OP_REMASK = 4'd10
  } alu_op_e;

  typedef enum logic [2:0] {
    CLS_NONE  = 3'd0,
    CLS_LOGIC = 3'd1,
    CLS_ARITH = 3'd2,
    CLS_SHIFT = 3'd3,
    CLS_MASK  = 3'd4
  } op_class_e;

  // Prefix carry steps for 32 bits, distances 1 to 16
  localparam int ADD_STEPS = 5;
  localparam int STEP_W    = $clog2(ADD_STEPS + 1);

endpackage

// ==== source/mask_lfsr.sv ====
`timescale 1ns/10ps

module mask_lfsr (
  input  logic                    g_clk,
  input  logic                    g_resetn,
  input  logic                    i_step,
  output mask_types_pkg::share_t  o_rand
);
  import mask_types_pkg::*;

  logic   feedback;
  share_t next_state;

  // XNOR taps 31, 21, 1, 0
  assign feedback   = o_rand[31] ~^ o_rand[21] ~^ o_rand[1] ~^ o_rand[0];
  assign next_state = {o_rand[30:0], feedback};

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      o_rand <= LFSR_SEED;
    end else if (i_step) begin
      o_rand <= next_state;     // One step per operation taken
    end
  end

endmodule

// ==== source/masked_shift.sv ====
`timescale 1ns/10ps

module masked_shift (
  input  mask_types_pkg::share_t                i_share,
  input  logic [mask_types_pkg::SHAMT_W-1:0]    i_shamt,
  input  mask_types_pkg::share_t                i_pad,
  input  alu_op_pkg::alu_op_e                   i_op,
  output mask_types_pkg::share_t                o_share
);
  import mask_types_pkg::*;
  import alu_op_pkg::*;

  // Level k moves by 2**k, each level pads from its own slice of i_pad
  always_comb begin : barrel
    share_t      lvl;
    share_t      low;
    int unsigned w;
    lvl = i_share;
    for (int k = 0; k < SHAMT_W; k++) begin
      w   = 1 << k;
      low = (share_t'(1) << w) - share_t'(1);
      if (i_shamt[k]) begin
        case (i_op)
          // Left pad comes from the top of the word downwards
          OP_SLLI: lvl = (lvl << w) | ((i_pad >> (XLEN - 2 * w + 1)) & low);
          // Rotate refills with the bits that fall off
          OP_RORI: lvl = (lvl >> w) | (lvl << (XLEN - w));
          OP_SRLI: lvl = (lvl >> w) | (((i_pad >> (w - 1)) & low) << (XLEN - w));
          default: lvl = lvl;
        endcase
      end
    end
    o_share = lvl;
  end

endmodule

// ==== source/masked_addsub.sv ====
`timescale 1ns/10ps

module masked_addsub #(
  parameter int P_XLEN = mask_types_pkg::XLEN
) (
  input  logic              g_clk,
  input  logic              g_resetn,
  input  logic              i_start,
  input  logic              i_sub,
  input  logic [P_XLEN-1:0] i_rand,
  input  logic [P_XLEN-1:0] i_p0,
  input  logic [P_XLEN-1:0] i_p1,
  input  logic [P_XLEN-1:0] i_g0,
  input  logic [P_XLEN-1:0] i_g1,
  output logic [P_XLEN-1:0] o_s0,
  output logic [P_XLEN-1:0] o_s1,
  output logic              o_done
);
  import alu_op_pkg::*;

  logic              busy;
  logic [STEP_W-1:0] step;          // Steps already registered
  logic [STEP_W-1:0] dist_idx;
  logic              step_en;
  logic [P_XLEN-1:0] tg0_q, tg1_q, tg2_q, tg3_q;
  logic [P_XLEN-1:0] tp0_q, tp1_q, tp2_q, tp3_q;
  logic [P_XLEN-1:0] p0, p1, g0, g1;
  logic [P_XLEN-1:0] pj0, pj1, gj0, gj1;

  assign o_done   = busy && (step == STEP_W'(ADD_STEPS));
  assign step_en  = i_start || (busy && !o_done);
  assign dist_idx = i_start ? '0 : step;

  // First step takes the execute stage outputs
  assign p0 = i_start ? i_p0 : (tp0_q ^ tp2_q);
  assign p1 = i_start ? i_p1 : (tp1_q ^ tp3_q);
  assign g0 = i_start ? i_g0 : (tg0_q ^ tg2_q);
  assign g1 = i_start ? i_g1 : (tg1_q ^ tg3_q);

  assign pj0 = p0 << (1 << dist_idx);     // Distances 1, 2, 4, 8, 16
  assign pj1 = p1 << (1 << dist_idx);
  assign gj0 = g0 << (1 << dist_idx);
  assign gj1 = g1 << (1 << dist_idx);

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      busy <= 1'b0;
      step <= '0;
    end else if (i_start) begin
      busy <= 1'b1;
      step <= STEP_W'(1);
    end else if (o_done) begin
      busy <= 1'b0;
    end else if (busy) begin
      step <= step + 1'b1;
    end
  end

  // G = G ^ (P & G<<d), P = P & P<<d, each product split over four terms
  always_ff @(posedge g_clk) begin
    if (step_en) begin
      tg0_q <= g0 ^ (gj0 & p0);
      tg1_q <= g1 ^ (gj1 & p0);
      tg2_q <= gj0 & p1;
      tg3_q <= gj1 & p1;
      tp0_q <= i_rand ^ (p0 & pj0);
      tp1_q <= i_rand ^ (p0 & pj1);
      tp2_q <= p1 & pj0;
      tp3_q <= p1 & pj1;
    end
  end

  // Sum = P ^ (G << 1), subtract carry in on share 1
  assign o_s0 = o_done ? (i_p0 ^ {g0[P_XLEN-2:0], 1'b0})  : '0;
  assign o_s1 = o_done ? (i_p1 ^ {g1[P_XLEN-2:0], i_sub}) : '0;

endmodule

// ==== source/op_decode.sv ====
`timescale 1ns/10ps

module op_decode (
  input  logic                       g_clk,
  input  logic                       g_resetn,
  input  logic                       i_cmd_valid,
  input  alu_op_pkg::alu_op_e        i_cmd_op,
  input  mask_types_pkg::share_t     i_rs1_s0,
  input  mask_types_pkg::share_t     i_rs1_s1,
  input  mask_types_pkg::share_t     i_rs2_s0,
  input  mask_types_pkg::share_t     i_rs2_s1,
  input  logic                       i_ex_take,
  output logic                       o_d_valid,
  output alu_op_pkg::op_class_e      o_d_class,
  output alu_op_pkg::alu_op_e        o_d_op,
  output mask_types_pkg::share_t     o_rs1_s0,
  output mask_types_pkg::share_t     o_rs1_s1,
  output mask_types_pkg::operand2_u  o_rs2_s0,
  output mask_types_pkg::share_t     o_rs2_s1,
  output logic                       o_cmd_credit
);
  import alu_op_pkg::*;

  op_class_e cmd_class;

  always_comb begin
    case (i_cmd_op)
      OP_NOT, OP_XOR, OP_AND, OP_IOR: cmd_class = CLS_LOGIC;
      OP_ADD, OP_SUB:                 cmd_class = CLS_ARITH;
      OP_SRLI, OP_SLLI, OP_RORI:      cmd_class = CLS_SHIFT;
      OP_MASK, OP_REMASK:             cmd_class = CLS_MASK;
      default:                        cmd_class = CLS_NONE;   // Reserved codes
    endcase
  end

  // Slot state and credit return
  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      o_d_valid    <= 1'b0;
      o_cmd_credit <= 1'b0;
    end else begin
      o_cmd_credit <= i_ex_take;    // Slot freed, one credit back
      if (i_cmd_valid) begin
        o_d_valid <= 1'b1;
      end else if (i_ex_take) begin
        o_d_valid <= 1'b0;
      end
    end
  end

  // Payload only loads when a command arrives
  always_ff @(posedge g_clk) begin
    if (i_cmd_valid) begin
      o_d_class     <= cmd_class;
      o_d_op        <= i_cmd_op;
      o_rs1_s0      <= i_rs1_s0;
      o_rs1_s1      <= i_rs1_s1;
      o_rs2_s0.data <= i_rs2_s0;
      o_rs2_s1      <= i_rs2_s1;
    end
  end

endmodule

// ==== source/masked_execute.sv ====
`timescale 1ns/10ps

module masked_execute #(
  parameter int P_XLEN = mask_types_pkg::XLEN
) (
  input  logic                       g_clk,
  input  logic                       g_resetn,
  input  logic                       i_d_valid,
  input  alu_op_pkg::op_class_e      i_d_class,
  input  alu_op_pkg::alu_op_e        i_d_op,
  input  logic [P_XLEN-1:0]          i_rs1_s0,
  input  logic [P_XLEN-1:0]          i_rs1_s1,
  input  mask_types_pkg::operand2_u  i_rs2_s0,
  input  logic [P_XLEN-1:0]          i_rs2_s1,
  input  logic                       i_res_room,
  output logic                       o_ex_take,
  output logic                       o_ex_done,
  output logic [P_XLEN-1:0]          o_ex_s0,
  output logic [P_XLEN-1:0]          o_ex_s1
);
  import mask_types_pkg::*;
  import alu_op_pkg::*;

  localparam logic [2:0] S_IDLE    = 3'd0;
  localparam logic [2:0] S_LOGIC   = 3'd1;
  localparam logic [2:0] S_MASK    = 3'd2;
  localparam logic [2:0] S_ADD_GO  = 3'd3;
  localparam logic [2:0] S_ADD_RUN = 3'd4;
  localparam logic [2:0] S_DONE    = 3'd5;

  logic [2:0]        state;
  alu_op_e           ex_op;
  share_t            rnd;
  share_t            shift_s0;
  share_t            shift_s1;
  logic [P_XLEN-1:0] a1_in;
  logic [P_XLEN-1:0] b1_in;
  logic [P_XLEN-1:0] x0_q, x1_q;
  logic [P_XLEN-1:0] t0_q, t1_q, t2_q, t3_q;
  logic [P_XLEN-1:0] and0, and1;
  logic [P_XLEN-1:0] g0_cin;
  logic [P_XLEN-1:0] g1_cin;
  logic [P_XLEN-1:0] mask_a0_q;
  logic [P_XLEN-1:0] mask_r_q;
  logic [P_XLEN-1:0] add_s0, add_s1;
  logic              add_done;
  logic              ti_load;
  logic              is_sub;

  assign o_ex_take = (state == S_IDLE) && i_d_valid;
  assign o_ex_done = (state == S_DONE) && i_res_room;   // Hold result while no credit
  assign ti_load   = o_ex_take && (i_d_class == CLS_LOGIC || i_d_class == CLS_ARITH);
  assign is_sub    = (ex_op == OP_SUB);

  // OR works as AND of the inverted operands
  assign a1_in = (i_d_op == OP_IOR) ? ~i_rs1_s1 : i_rs1_s1;
  assign b1_in = (i_d_op == OP_IOR || i_d_op == OP_SUB) ? ~i_rs2_s1 : i_rs2_s1;

  assign and0   = t0_q ^ t2_q;
  assign and1   = t1_q ^ t3_q;
  // Carry in at bit 0 folds each share of P[0] into its own share of G[0]
  assign g0_cin = {and0[P_XLEN-1:1], and0[0] ^ (x0_q[0] & is_sub)};
  assign g1_cin = {and1[P_XLEN-1:1], and1[0] ^ (x1_q[0] & is_sub)};

  mask_lfsr u_mask_lfsr (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_step   (o_ex_take),
    .o_rand   (rnd)
  );

  masked_shift u_shift_s0 (
    .i_share (i_rs1_s0),
    .i_shamt (i_rs2_s0.shift.shamt),
    .i_pad   (rnd),
    .i_op    (i_d_op),
    .o_share (shift_s0)
  );

  // Same padding as share 0 so it cancels
  masked_shift u_shift_s1 (
    .i_share (i_rs1_s1),
    .i_shamt (i_rs2_s0.shift.shamt),
    .i_pad   (rnd),
    .i_op    (i_d_op),
    .o_share (shift_s1)
  );

  masked_addsub #(
    .P_XLEN (P_XLEN)
  ) u_masked_addsub (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_start  (state == S_ADD_GO),
    .i_sub    (is_sub),
    .i_rand   (rnd),
    .i_p0     (x0_q),
    .i_p1     (x1_q),
    .i_g0     (g0_cin),
    .i_g1     (g1_cin),
    .o_s0     (add_s0),
    .o_s1     (add_s1),
    .o_done   (add_done)
  );

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (o_ex_take) begin
            case (i_d_class)
              CLS_LOGIC: state <= (i_d_op == OP_NOT) ? S_DONE : S_LOGIC;
              CLS_ARITH: state <= S_ADD_GO;
              CLS_MASK:  state <= S_MASK;
              default:   state <= S_DONE;     // Shifts and reserved ops
            endcase
          end
        end
        S_LOGIC, S_MASK: state <= S_DONE;
        S_ADD_GO:        state <= S_ADD_RUN;
        S_ADD_RUN:       state <= add_done ? S_DONE : S_ADD_RUN;
        S_DONE:          state <= i_res_room ? S_IDLE : S_DONE;
        default:         state <= S_IDLE;
      endcase
    end
  end

  // Threshold stage with share 0 terms guarded by fresh randomness
  always_ff @(posedge g_clk) begin
    if (o_ex_take) begin
      ex_op <= i_d_op;
    end
    if (ti_load) begin
      x0_q <= i_rs1_s0 ^ i_rs2_s0.data;
      x1_q <= a1_in ^ b1_in;
      t0_q <= rnd ^ (i_rs1_s0 & i_rs2_s0.data);
      t1_q <= rnd ^ (i_rs1_s0 & b1_in);
      t2_q <= a1_in & i_rs2_s0.data;
      t3_q <= a1_in & b1_in;
    end
    if (o_ex_take && i_d_class == CLS_MASK) begin
      mask_a0_q <= i_rs1_s0 ^ rnd;
      mask_r_q  <= rnd;
    end
  end

  always_ff @(posedge g_clk) begin
    case (state)
      S_IDLE: begin
        if (o_ex_take) begin
          case (i_d_class)
            CLS_LOGIC: begin            // NOT only touches share 1
              o_ex_s0 <= i_rs1_s0;
              o_ex_s1 <= ~i_rs1_s1;
            end
            CLS_SHIFT: begin
              o_ex_s0 <= shift_s0;
              o_ex_s1 <= shift_s1;
            end
            default: begin
              o_ex_s0 <= '0;
              o_ex_s1 <= '0;
            end
          endcase
        end
      end
      S_LOGIC: begin
        case (ex_op)
          OP_XOR: begin
            o_ex_s0 <= x0_q;
            o_ex_s1 <= x1_q;
          end
          OP_AND: begin
            o_ex_s0 <= and0;
            o_ex_s1 <= and1;
          end
          default: begin
            o_ex_s0 <= and0;
            o_ex_s1 <= ~and1;           // Undo the OR inversion
          end
        endcase
      end
      S_MASK: begin
        // Remask folds the old share 1 in after the register
        o_ex_s0 <= (ex_op == OP_REMASK) ? (mask_a0_q ^ i_rs1_s1) : mask_a0_q;
        o_ex_s1 <= mask_r_q;
      end
      S_ADD_RUN: begin
        if (add_done) begin
          o_ex_s0 <= add_s0;
          o_ex_s1 <= add_s1;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== source/result_credit.sv ====
`timescale 1ns/10ps

module result_credit #(
  parameter int P_XLEN        = mask_types_pkg::XLEN,
  parameter int P_RES_CREDITS = 2
) (
  input  logic              g_clk,
  input  logic              g_resetn,
  input  logic              i_ex_done,
  input  logic [P_XLEN-1:0] i_ex_s0,
  input  logic [P_XLEN-1:0] i_ex_s1,
  input  logic              i_res_credit,
  output logic              o_res_room,
  output logic              o_res_valid,
  output logic [P_XLEN-1:0] o_rd_s0,
  output logic [P_XLEN-1:0] o_rd_s1
);

  localparam int CNT_W = $clog2(P_RES_CREDITS + 1);

  logic [CNT_W-1:0] credits;

  assign o_res_room = (credits != '0);

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      credits     <= CNT_W'(P_RES_CREDITS);
      o_res_valid <= 1'b0;
    end else begin
      o_res_valid <= i_ex_done;
      case ({i_ex_done, i_res_credit})
        2'b10:   credits <= credits - 1'b1;   // Spent on this result
        2'b01:   credits <= credits + 1'b1;   // Returned by consumer
        default: credits <= credits;          // Both or neither
      endcase
    end
  end

  always_ff @(posedge g_clk) begin
    if (i_ex_done) begin
      o_rd_s0 <= i_ex_s0;
      o_rd_s1 <= i_ex_s1;
    end
  end

endmodule

// ==== source/masked_alu_top.sv ====
`timescale 1ns/10ps

module masked_alu_top #(
  parameter int P_XLEN        = mask_types_pkg::XLEN,
  parameter int P_RES_CREDITS = 2
) (
  input  logic                    g_clk,
  input  logic                    g_resetn,
  input  logic                    i_cmd_valid,
  input  alu_op_pkg::alu_op_e     i_cmd_op,
  input  mask_types_pkg::share_t  i_rs1_s0,
  input  mask_types_pkg::share_t  i_rs1_s1,
  input  mask_types_pkg::share_t  i_rs2_s0,
  input  mask_types_pkg::share_t  i_rs2_s1,
  output logic                    o_cmd_credit,
  output logic                    o_res_valid,
  output mask_types_pkg::share_t  o_rd_s0,
  output mask_types_pkg::share_t  o_rd_s1,
  input  logic                    i_res_credit
);
  import mask_types_pkg::*;
  import alu_op_pkg::*;

  logic              d_valid;
  op_class_e         d_class;
  alu_op_e           d_op;
  share_t            d_rs1_s0;
  share_t            d_rs1_s1;
  operand2_u         d_rs2_s0;    // Data share or shift amount
  share_t            d_rs2_s1;
  logic              ex_take;
  logic              ex_done;
  logic [P_XLEN-1:0] ex_s0;
  logic [P_XLEN-1:0] ex_s1;
  logic              res_room;

  op_decode u_op_decode (
    .g_clk        (g_clk),
    .g_resetn     (g_resetn),
    .i_cmd_valid  (i_cmd_valid),
    .i_cmd_op     (i_cmd_op),
    .i_rs1_s0     (i_rs1_s0),
    .i_rs1_s1     (i_rs1_s1),
    .i_rs2_s0     (i_rs2_s0),
    .i_rs2_s1     (i_rs2_s1),
    .i_ex_take    (ex_take),
    .o_d_valid    (d_valid),
    .o_d_class    (d_class),
    .o_d_op       (d_op),
    .o_rs1_s0     (d_rs1_s0),
    .o_rs1_s1     (d_rs1_s1),
    .o_rs2_s0     (d_rs2_s0),
    .o_rs2_s1     (d_rs2_s1),
    .o_cmd_credit (o_cmd_credit)
  );

  masked_execute #(
    .P_XLEN (P_XLEN)
  ) u_masked_execute (
    .g_clk      (g_clk),
    .g_resetn   (g_resetn),
    .i_d_valid  (d_valid),
    .i_d_class  (d_class),
    .i_d_op     (d_op),
    .i_rs1_s0   (d_rs1_s0),
    .i_rs1_s1   (d_rs1_s1),
    .i_rs2_s0   (d_rs2_s0),
    .i_rs2_s1   (d_rs2_s1),
    .i_res_room (res_room),
    .o_ex_take  (ex_take),
    .o_ex_done  (ex_done),
    .o_ex_s0    (ex_s0),
    .o_ex_s1    (ex_s1)
  );

  result_credit #(
    .P_XLEN        (P_XLEN),
    .P_RES_CREDITS (P_RES_CREDITS)
  ) u_result_credit (
    .g_clk        (g_clk),
    .g_resetn     (g_resetn),
    .i_ex_done    (ex_done),
    .i_ex_s0      (ex_s0),
    .i_ex_s1      (ex_s1),
    .i_res_credit (i_res_credit),
    .o_res_room   (res_room),
    .o_res_valid  (o_res_valid),
    .o_rd_s0      (o_rd_s0),
    .o_rd_s1      (o_rd_s1)
  );

endmodule

// ==== bench/tb_masked_alu.sv ====
`timescale 1ns/10ps

module tb_masked_alu;
  import mask_types_pkg::*;
  import alu_op_pkg::*;

  localparam int RES_CREDITS = 2;
  localparam int TIMEOUT     = 200;   // Cycles allowed for any single wait
  localparam int SLOW_RET    = 15;    // Result credit delay for the burst rows

  logic    g_clk;
  logic    g_resetn;
  logic    i_cmd_valid;
  alu_op_e i_cmd_op;
  share_t  i_rs1_s0;
  share_t  i_rs1_s1;
  share_t  i_rs2_s0;
  share_t  i_rs2_s1;
  logic    o_cmd_credit;
  logic    o_res_valid;
  share_t  o_rd_s0;
  share_t  o_rd_s1;
  logic    i_res_credit;

  // Stimulus table with one entry per row
  alu_op_e row_op[$];
  share_t  row_a[$];
  share_t  row_b[$];
  share_t  row_exp[$];
  int      row_dly[$];

  // Commands in flight with the oldest first
  alu_op_e exp_op_q[$];
  share_t  exp_val_q[$];
  int      exp_idx_q[$];
  int      exp_dly_q[$];
  int      ret_q[$];                  // Delay of each credit still owed

  share_t  lcg_state;
  int      cmd_credits;
  int      res_credits;
  int      errors;
  int      tests_done;
  int      tests_failed;

  masked_alu_top #(
    .P_RES_CREDITS (RES_CREDITS)
  ) u_masked_alu_top (
    .g_clk        (g_clk),
    .g_resetn     (g_resetn),
    .i_cmd_valid  (i_cmd_valid),
    .i_cmd_op     (i_cmd_op),
    .i_rs1_s0     (i_rs1_s0),
    .i_rs1_s1     (i_rs1_s1),
    .i_rs2_s0     (i_rs2_s0),
    .i_rs2_s1     (i_rs2_s1),
    .o_cmd_credit (o_cmd_credit),
    .o_res_valid  (o_res_valid),
    .o_rd_s0      (o_rd_s0),
    .o_rd_s1      (o_rd_s1),
    .i_res_credit (i_res_credit)
  );

  initial begin
    g_clk = 1'b0;
    forever #5 g_clk = ~g_clk;
  end

  function automatic share_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic void add_row(alu_op_e op, share_t a, share_t b, share_t exp, int dly);
    row_op.push_back(op);
    row_a.push_back(a);
    row_b.push_back(b);
    row_exp.push_back(exp);
    row_dly.push_back(dly);
  endfunction

  task automatic check_value(input string name, input share_t got, input share_t exp,
                             inout bit ok);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
      ok = 1'b0;
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_done, tests_failed,
             errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  // Split the row into shares and issue it once a command credit is held
  task automatic send_row(input int idx, output bit sent);
    int      wait_cnt;
    share_t  r1;
    share_t  r2;
    alu_op_e op;
    op       = row_op[idx];
    r1       = lcg_next();
    r2       = lcg_next();
    wait_cnt = 0;
    @(posedge g_clk);
    i_cmd_valid <= 1'b0;
    while (cmd_credits == 0 && wait_cnt < TIMEOUT) begin
      @(posedge g_clk);
      wait_cnt++;
    end
    if (cmd_credits == 0) begin
      $display("Timeout: no command credit came back before test %0d", idx);
      errors++;
      sent = 1'b0;
    end else begin
      i_cmd_valid <= 1'b1;
      i_cmd_op    <= op;
      if (op == OP_MASK) begin
        i_rs1_s0 <= row_a[idx];         // Mask takes a plain value in share 0
        i_rs1_s1 <= r1;
      end else begin
        i_rs1_s0 <= r1;
        i_rs1_s1 <= row_a[idx] ^ r1;
      end
      if (op inside {OP_SRLI, OP_SLLI, OP_RORI}) begin
        i_rs2_s0 <= {r2[XLEN-1:SHAMT_W], row_b[idx][SHAMT_W-1:0]};
        i_rs2_s1 <= '0;
      end else begin
        i_rs2_s0 <= r2;
        i_rs2_s1 <= row_b[idx] ^ r2;
      end
      cmd_credits--;
      exp_op_q.push_back(op);
      exp_val_q.push_back(row_exp[idx]);
      exp_idx_q.push_back(idx);
      exp_dly_q.push_back(row_dly[idx]);
      sent = 1'b1;
    end
  endtask

  // Monitor samples the outputs on the falling edge
  always @(negedge g_clk) begin : monitor
    bit      ok;
    alu_op_e cur_op;
    if (g_resetn) begin
      if (o_cmd_credit) begin
        if (cmd_credits != 0) begin
          $display("Error at %0t ns: command credit returned with no command pending", $time);
          errors++;
        end
        cmd_credits++;
      end
      if (o_res_valid) begin
        if (res_credits == 0) begin
          $display("Error at %0t ns: result sent with no result credit left", $time);
          errors++;
        end else begin
          res_credits--;
        end
        if (exp_op_q.size() == 0) begin
          $display("Error at %0t ns: result arrived with no command outstanding", $time);
          errors++;
        end else begin
          ok     = 1'b1;
          cur_op = exp_op_q[0];
          if (cur_op > OP_REMASK) begin   // Reserved code clears both shares
            check_value("o_rd_s0", o_rd_s0, '0, ok);
            check_value("o_rd_s1", o_rd_s1, '0, ok);
          end else begin
            check_value("o_rd_s0^o_rd_s1", o_rd_s0 ^ o_rd_s1, exp_val_q[0], ok);
          end
          $display("Test %0d %s: %s", exp_idx_q[0],
                   (cur_op > OP_REMASK) ? "RESERVED" : cur_op.name(), ok ? "ok" : "failed");
          tests_done++;
          if (!ok) begin
            tests_failed++;
          end
          ret_q.push_back(exp_dly_q[0]);
          void'(exp_op_q.pop_front());
          void'(exp_val_q.pop_front());
          void'(exp_idx_q.pop_front());
          void'(exp_dly_q.pop_front());
        end
      end
      if (i_res_credit) begin
        res_credits++;
      end
    end
  end

  // Consumer hands result credits back after the row's delay
  always @(posedge g_clk) begin : credit_return
    int ret_wait;
    if (!g_resetn) begin
      i_res_credit <= 1'b0;
      ret_wait = 0;
    end else begin
      i_res_credit <= 1'b0;
      if (ret_q.size() > 0) begin
        if (ret_wait >= ret_q[0]) begin
          i_res_credit <= 1'b1;
          void'(ret_q.pop_front());
          ret_wait = 0;
        end else begin
          ret_wait++;
        end
      end
    end
  end

  initial begin : stimulus
    int wait_cnt;
    bit ok;
    bit sent;
    g_resetn     = 1'b0;
    i_cmd_valid  = 1'b0;
    i_cmd_op     = OP_NOT;
    i_rs1_s0     = '0;
    i_rs1_s1     = '0;
    i_rs2_s0     = '0;
    i_rs2_s1     = '0;
    i_res_credit = 1'b0;
    lcg_state    = 32'd74753;
    cmd_credits  = 1;               // Depth of the decode slot
    res_credits  = RES_CREDITS;
    errors       = 0;
    tests_done   = 0;
    tests_failed = 0;
    ok           = 1'b1;
    sent         = 1'b1;

    // Logic and arithmetic with carry chains
    add_row(OP_NOT, 32'h0f0f_1234, 32'h0000_0000, 32'hf0f0_edcb, 0);
    add_row(OP_XOR, 32'hdead_beef, 32'h1234_5678, 32'hcc99_e897, 0);
    add_row(OP_AND, 32'hdead_beef, 32'h1234_5678, 32'h1224_1668, 0);
    add_row(OP_IOR, 32'hdead_beef, 32'h1234_5678, 32'hdebd_feff, 0);
    add_row(OP_ADD, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 0);
    add_row(OP_ADD, 32'h1234_5678, 32'h0fed_cba9, 32'h2222_2221, 0);
    add_row(OP_SUB, 32'h0000_0005, 32'h0000_0007, 32'hffff_fffe, 0);
    add_row(OP_SUB, 32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff, 0);
    // Shifts by 0, 1, 17 and 31
    add_row(OP_SRLI, 32'h8123_4567, 32'd0,  32'h8123_4567, 0);
    add_row(OP_SRLI, 32'h8123_4567, 32'd1,  32'h4091_a2b3, 0);
    add_row(OP_SRLI, 32'h8123_4567, 32'd17, 32'h0000_4091, 0);
    add_row(OP_SRLI, 32'h8123_4567, 32'd31, 32'h0000_0001, 0);
    add_row(OP_SLLI, 32'h8123_4567, 32'd0,  32'h8123_4567, 0);
    add_row(OP_SLLI, 32'h8123_4567, 32'd1,  32'h0246_8ace, 0);
    add_row(OP_SLLI, 32'h8123_4567, 32'd17, 32'h8ace_0000, 0);
    add_row(OP_SLLI, 32'h8123_4567, 32'd31, 32'h8000_0000, 0);
    add_row(OP_RORI, 32'h8123_4567, 32'd0,  32'h8123_4567, 0);
    add_row(OP_RORI, 32'h8123_4567, 32'd1,  32'hc091_a2b3, 0);
    add_row(OP_RORI, 32'h8123_4567, 32'd17, 32'ha2b3_c091, 0);
    add_row(OP_RORI, 32'h8123_4567, 32'd31, 32'h0246_8acf, 0);
    add_row(OP_MASK, 32'h5a5a_1234, 32'h0000_0000, 32'h5a5a_1234, 0);
    add_row(OP_REMASK, 32'hc3c3_9876, 32'h0000_0000, 32'hc3c3_9876, 0);
    add_row(alu_op_e'(4'd13), 32'h1111_2222, 32'h3333_4444, 32'h0000_0000, 0);
    // Mixed burst while result credits come back slowly
    add_row(OP_ADD, 32'h7fff_ffff, 32'h7fff_ffff, 32'hffff_fffe, SLOW_RET);
    add_row(OP_SUB, 32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, SLOW_RET);
    add_row(OP_XOR, 32'hffff_0000, 32'h0f0f_0f0f, 32'hf0f0_0f0f, SLOW_RET);
    add_row(OP_NOT, 32'h0000_0000, 32'h0000_0000, 32'hffff_ffff, SLOW_RET);
    add_row(OP_AND, 32'hffff_0000, 32'h0f0f_0f0f, 32'h0f0f_0000, SLOW_RET);
    add_row(OP_SRLI, 32'hffff_ffff, 32'd4, 32'h0fff_ffff, SLOW_RET);
    add_row(OP_IOR, 32'h1200_0034, 32'h0056_7800, 32'h1256_7834, SLOW_RET);
    add_row(OP_REMASK, 32'h0bad_f00d, 32'h0000_0000, 32'h0bad_f00d, SLOW_RET);
    add_row(OP_MASK, 32'h600d_cafe, 32'h0000_0000, 32'h600d_cafe, SLOW_RET);

    repeat (2) @(posedge g_clk);
    g_resetn <= 1'b1;
    @(negedge g_clk);
    check_value("o_res_valid", share_t'(o_res_valid), '0, ok);
    check_value("o_cmd_credit", share_t'(o_cmd_credit), '0, ok);

    for (int i = 0; i < row_op.size() && sent; i++) begin
      send_row(i, sent);
    end
    @(posedge g_clk);
    i_cmd_valid <= 1'b0;

    if (sent) begin
      wait_cnt = 0;
      while (exp_op_q.size() > 0 && wait_cnt < TIMEOUT) begin
        @(posedge g_clk);
        wait_cnt++;
      end
      if (exp_op_q.size() > 0) begin
        $display("Timeout: %0d results never arrived", exp_op_q.size());
        errors++;
      end
    end
    finish_run();
  end

endmodule

// ==== files.f ====
source/mask_types_pkg.sv
source/alu_op_pkg.sv
source/mask_lfsr.sv
source/masked_shift.sv
source/masked_addsub.sv
source/op_decode.sv
source/masked_execute.sv
source/result_credit.sv
source/masked_alu_top.sv
bench/tb_masked_alu.sv
